/* div_operand_prep.sv */
// Divider input stage, registers a request as operand magnitudes plus sign flags.
`timescale 1ns/1ps

module div_operand_prep (
    // Pipeline clock.
    input  logic               clk,
    // Asynchronous reset, active low.
    input  logic               arst_n,
    // Request strobe.
    input  logic               in_valid,
    // Request operands and mode.
    input  div_pkg::div_req_t  req,
    // First pipeline word.
    output div_pkg::div_pipe_t pipe_out
);
    import div_pkg::*;

    // Operand signs, only meaningful in signed mode.
    logic dvd_neg;
    logic dvs_neg;

    // Operand magnitudes.
    word_t dvd_mag;
    word_t dvs_mag;

    // Next pipeline word.
    div_pipe_t pipe_d;

    // Data register, no reset.
    div_pipe_t pipe_q;

    // Valid register, the only reset state here.
    logic valid_q;

    // Sign detection.
    // Top bit counts as a sign only in signed mode.
    always_comb begin
        dvd_neg = !req.is_unsigned && req.dividend[DATA_W-1];
        dvs_neg = !req.is_unsigned && req.divisor[DATA_W-1];
    end

    // Magnitudes.
    // Most negative value maps to itself, fine as unsigned.
    always_comb begin
        dvd_mag = dvd_neg ? twos_neg(req.dividend) : req.dividend;
        dvs_mag = dvs_neg ? twos_neg(req.divisor) : req.divisor;
    end

    // Build the first pipeline word.
    always_comb begin
        pipe_d                = '0;
        pipe_d.rem            = dvd_mag;
        pipe_d.divisor        = dvs_mag;
        // No quotient bits resolved yet.
        pipe_d.quot           = '0;
        pipe_d.flags          = FLAGS_NONE;
        pipe_d.flags.valid    = in_valid;
        // Exactly one negative operand.
        pipe_d.flags.neg_quot = dvd_neg ^ dvs_neg;
        // Remainder follows the dividend.
        pipe_d.flags.neg_rem  = dvd_neg;
        pipe_d.flags.div_zero = (req.divisor == '0);
    end

    // Valid bit.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        pipe_q <= pipe_d;
    end

    // Output word with the reset valid bit merged in.
    always_comb begin
        pipe_out             = pipe_q;
        pipe_out.flags.valid = valid_q;
    end

endmodule

/* div_pkg.sv */
// Pipelined divider package with word, flag, request, result and stage types.
package div_pkg;

    // Operand width in bits.
    localparam int DATA_W = 32;

    // One operand or result word.
    typedef logic [DATA_W-1:0] word_t;

    // Double-width word for the shifted divisor compare.
    // Keeps divisor bits shifted past the top of the word.
    typedef logic [2*DATA_W-1:0] dword_t;

    // Per-request flags, carried along with the data.
    typedef struct packed {
        // Live request in this slot.
        logic valid;
        // Quotient needs two's complement at the end.
        logic neg_quot;
        // Remainder needs two's complement at the end.
        logic neg_rem;
        // Divisor was zero.
        logic div_zero;
    } div_flags_t;

    // Request as presented at the top level.
    typedef struct packed {
        // Numerator.
        word_t dividend;
        // Denominator.
        word_t divisor;
        // High selects unsigned division.
        logic  is_unsigned;
    } div_req_t;

    // Result as returned at the top level.
    typedef struct packed {
        // Truncated toward zero in signed mode.
        word_t quotient;
        // Takes the sign of the dividend in signed mode.
        word_t remainder;
    } div_res_t;

    // Stage-to-stage pipeline word.
    typedef struct packed {
        // Partial remainder, starts as dividend magnitude.
        word_t      rem;
        // Divisor magnitude, never shifted in place.
        word_t      divisor;
        // Quotient bits resolved so far.
        word_t      quot;
        // Request flags.
        div_flags_t flags;
    } div_pipe_t;

    // Empty flag set.
    localparam div_flags_t FLAGS_NONE = '{
        valid:    1'b0,
        neg_quot: 1'b0,
        neg_rem:  1'b0,
        div_zero: 1'b0
    };

    // Two's complement helper.
    function automatic word_t twos_neg(input word_t value);
        return ~value + word_t'(1);
    endfunction

endpackage

/* div_result_fix.sv */
// Divider output stage, restores signs, applies the zero-divisor rule and registers the result.
`timescale 1ns/1ps

module div_result_fix (
    // Pipeline clock.
    input  logic               clk,
    // Asynchronous reset, active low.
    input  logic               arst_n,
    // Word from the last stage.
    input  div_pkg::div_pipe_t pipe_in,
    // One-cycle result strobe.
    output logic               out_valid,
    // Quotient and remainder.
    output div_pkg::div_res_t  res
);
    import div_pkg::*;

    // Signed quotient before the zero rule.
    word_t quot_signed;

    // Signed remainder.
    word_t rem_signed;

    // Next result.
    div_res_t res_d;

    // Result register, no reset.
    div_res_t res_q;

    // Strobe register.
    logic valid_q;

    // Sign restore.
    always_comb begin
        quot_signed = pipe_in.flags.neg_quot ? twos_neg(pipe_in.quot) : pipe_in.quot;
        rem_signed  = pipe_in.flags.neg_rem ? twos_neg(pipe_in.rem) : pipe_in.rem;
    end

    // Zero divisor gives all ones.
    // Remainder is still the dividend magnitude then.
    // The sign fix above turns it back into the dividend.
    always_comb begin
        res_d.quotient  = pipe_in.flags.div_zero ? '1 : quot_signed;
        res_d.remainder = rem_signed;
    end

    // Strobe.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pipe_in.flags.valid;
        end
    end

    // Result.
    always_ff @(posedge clk) begin
        res_q <= res_d;
    end

    // Outputs.
    assign out_valid = valid_q;
    assign res       = res_q;

endmodule

/* div_stage.sv */
// Divider pipeline stage, resolves a group of quotient bits by restoring subtraction.
`timescale 1ns/1ps

module div_stage #(
    // Quotient bits resolved here.
    parameter int STEP_BITS = 4,
    // Position of this stage in the chain.
    parameter int STAGE_IDX = 0
) (
    // Pipeline clock.
    input  logic               clk,
    // Asynchronous reset, active low.
    input  logic               arst_n,
    // Word from the previous stage.
    input  div_pkg::div_pipe_t pipe_in,
    // Word to the next stage.
    output div_pkg::div_pipe_t pipe_out
);
    import div_pkg::*;

    // Highest quotient bit handled here.
    localparam int TOP_BIT = DATA_W - 1 - STAGE_IDX * STEP_BITS;

    // Working partial remainder.
    word_t rem_v;

    // Working quotient.
    word_t quot_v;

    // Divisor shifted to the current bit.
    dword_t shifted;

    // Remainder widened for the compare.
    dword_t rem_wide;

    // Next pipeline word.
    div_pipe_t pipe_d;

    // Data register, no reset.
    div_pipe_t pipe_q;

    // Valid register.
    logic valid_q;

    // Restoring division over STEP_BITS positions.
    // Walks from TOP_BIT downward.
    always_comb begin
        rem_v    = pipe_in.rem;
        quot_v   = pipe_in.quot;
        shifted  = '0;
        rem_wide = '0;
        for (int i = 0; i < STEP_BITS; i++) begin
            // Double width, so high divisor bits still block the subtract.
            shifted  = dword_t'(pipe_in.divisor) << (TOP_BIT - i);
            rem_wide = dword_t'(rem_v);
            if (rem_wide >= shifted) begin
                // Upper half is zero here.
                rem_v               = rem_v - shifted[DATA_W-1:0];
                quot_v[TOP_BIT - i] = 1'b1;
            end
        end
    end

    // Divisor and flags pass straight through.
    always_comb begin
        pipe_d      = pipe_in;
        pipe_d.rem  = rem_v;
        pipe_d.quot = quot_v;
    end

    // Valid bit.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pipe_in.flags.valid;
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        pipe_q <= pipe_d;
    end

    // Output word.
    always_comb begin
        pipe_out             = pipe_q;
        pipe_out.flags.valid = valid_q;
    end

endmodule

/* div_top.sv */
// Pipelined 32-bit divider with fixed latency, one request per cycle.
`timescale 1ns/1ps

module div_top #(
    // Quotient bits per stage, must divide DATA_W.
    parameter int STEP_BITS = 4
) (
    // Pipeline clock.
    input  logic              clk,
    // Asynchronous reset, active low.
    input  logic              arst_n,
    // Request strobe, no ready.
    input  logic              in_valid,
    // Request operands and mode.
    input  div_pkg::div_req_t req,
    // Result strobe.
    output logic              out_valid,
    // Result.
    output div_pkg::div_res_t res
);
    import div_pkg::*;

    // Number of division stages.
    localparam int NUM_STAGES = DATA_W / STEP_BITS;

    // Pipeline words between blocks.
    // Index 0 from the prep stage, last one into the fix stage.
    div_pipe_t pipe [NUM_STAGES+1];

    // Operand preparation.
    // One cycle.
    div_operand_prep u_prep (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .req      (req),
        .pipe_out (pipe[0])
    );

    // Division stages.
    // One cycle each, highest quotient bits first.
    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
        div_stage #(
            .STEP_BITS (STEP_BITS),
            .STAGE_IDX (s)
        ) u_stage (
            .clk      (clk),
            .arst_n   (arst_n),
            .pipe_in  (pipe[s]),
            .pipe_out (pipe[s+1])
        );
    end

    // Sign and zero fix.
    // One cycle, total NUM_STAGES + 2.
    div_result_fix u_fix (
        .clk       (clk),
        .arst_n    (arst_n),
        .pipe_in   (pipe[NUM_STAGES]),
        .out_valid (out_valid),
        .res       (res)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build the divider testbench with Verilator and run it.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_div_top -o tb_div_top &&
./obj_dir/tb_div_top ||
{ echo "divider simulation failed"; exit 1; }

/* sim.f */
+incdir+.
div_pkg.sv
div_operand_prep.sv
div_stage.sv
div_result_fix.sv
div_top.sv
tb_div_top.sv

/* tb_div_model.svh */
// Divider reference model, expected quotient and remainder for one request.
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// Expected result of one request.
// Works in 64 bits so the most negative over minus one does not overflow.
function automatic div_pkg::div_res_t div_model(input div_pkg::div_req_t req);
    div_pkg::div_res_t exp_res;
    longint            dvd_wide;
    longint            dvs_wide;
    longint            quot_wide;
    longint            rem_wide;

    // Zero divisor, all ones and the dividend back.
    if (req.divisor == '0) begin
        exp_res.quotient  = '1;
        exp_res.remainder = req.dividend;
        return exp_res;
    end

    // Widen per mode.
    if (req.is_unsigned) begin
        dvd_wide = longint'(req.dividend);
        dvs_wide = longint'(req.divisor);
    end else begin
        dvd_wide = longint'($signed(req.dividend));
        dvs_wide = longint'($signed(req.divisor));
    end

    // Truncating division, remainder follows the dividend.
    quot_wide = dvd_wide / dvs_wide;
    rem_wide  = dvd_wide % dvs_wide;

    // Back to one word.
    exp_res.quotient  = div_pkg::word_t'(quot_wide);
    exp_res.remainder = div_pkg::word_t'(rem_wide);
    return exp_res;
endfunction

// Request as text, for failure messages.
function automatic string div_req_str(input div_pkg::div_req_t req);
    return $sformatf("%s %08h / %08h",
                     req.is_unsigned ? "unsigned" : "signed",
                     req.dividend, req.divisor);
endfunction

// Result as text, for failure messages.
function automatic string div_res_str(input div_pkg::div_res_t res);
    return $sformatf("quot %08h rem %08h", res.quotient, res.remainder);
endfunction

`endif

/* tb_div_top.sv */
// Testbench for the pipelined divider, checks results and latency against a model.
`timescale 1ns/1ps

module tb_div_top;
    import div_pkg::*;

    `include "tb_div_model.svh"

    // Run constants.
    localparam logic [31:0] SEED            = 32'h535d_0d7c;
    localparam int          NUM_CORNERS     = 12;
    localparam int          NUM_DIRECTED    = NUM_CORNERS * NUM_CORNERS * 2;
    localparam int          NUM_RANDOM      = 300;
    localparam int          NUM_REQ         = NUM_DIRECTED + NUM_RANDOM;
    localparam int          WATCHDOG_CYCLES = NUM_REQ * 20 + 200;
    // Prep stage, eight stages of four bits, fix stage.
    localparam int          LATENCY         = DATA_W / 4 + 2;

    // Operand corners, mixed into both phases.
    localparam word_t CORNERS [NUM_CORNERS] = '{
        32'h0000_0000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003,
        32'h0000_0007, 32'h7fff_ffff, 32'h8000_0000, 32'h8000_0001,
        32'hffff_ffff, 32'hffff_fffe, 32'h0001_0000, 32'hdead_beef
    };

    // One outstanding request and its due cycle.
    typedef struct packed {
        logic [31:0] due;
        div_req_t    req;
        div_res_t    res;
    } expect_t;

    // DUT ports.
    logic     clk;
    logic     arst_n;
    logic     in_valid;
    div_req_t req;
    logic     out_valid;
    div_res_t res;

    // Scoreboard state.
    expect_t     exp_q [$];
    expect_t     exp_cur;
    logic        exp_valid;
    logic [31:0] cycle;
    int          sent;

    div_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .res       (res)
    );

    // 100 ns clock.
    always #50 clk = ~clk;

    // Edge counter, read by stimulus and scoreboard.
    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // Scoreboard head for the cycle that just started.
    // Runs after stimulus, so a push at +1 ns is already visible.
    always @(posedge clk) begin
        #2;
        exp_valid = 1'b0;
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            exp_valid = 1'b1;
            exp_cur   = exp_q.pop_front();
        end
    end

    // Prints a mismatch and ends the run.
    task automatic report_mismatch(input string sig, input word_t exp_val,
                                   input word_t got_val, input bit show_req);
        $display("[FAIL] %s expected %08h got %08h at cycle %0d",
                 sig, exp_val, got_val, cycle);
        if (show_req) begin
            $display("  request %s, model %s",
                     div_req_str(exp_cur.req), div_res_str(exp_cur.res));
        end
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    // Strobe timing, no missing or extra pulses.
    assert property (@(negedge clk) disable iff (!arst_n) out_valid == exp_valid)
        else report_mismatch("out_valid", word_t'(exp_valid), word_t'(out_valid), 1'b0);

    // Quotient of the due request.
    assert property (@(negedge clk) disable iff (!arst_n)
                     !exp_valid || res.quotient == exp_cur.res.quotient)
        else report_mismatch("res.quotient", exp_cur.res.quotient, res.quotient, 1'b1);

    // Remainder of the due request.
    assert property (@(negedge clk) disable iff (!arst_n)
                     !exp_valid || res.remainder == exp_cur.res.remainder)
        else report_mismatch("res.remainder", exp_cur.res.remainder, res.remainder, 1'b1);

    // Random operand, biased toward corners and small values.
    function automatic word_t pick_operand();
        word_t value;
        case ($urandom_range(0, 3))
            0: value = CORNERS[$urandom_range(0, NUM_CORNERS - 1)];
            1: value = $urandom();
            2: value = $urandom() >> $urandom_range(0, 31);
            // Small negative in signed mode.
            default: value = ~($urandom() >> $urandom_range(0, 31));
        endcase
        return value;
    endfunction

    // One accepted request, expectation queued with its due cycle.
    task automatic send_request(input div_req_t r);
        expect_t e;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        req      = r;
        // Sampled on the next edge, result due LATENCY cycles after this one.
        e.due = cycle + 32'(LATENCY);
        e.req = r;
        e.res = div_model(r);
        exp_q.push_back(e);
        sent++;
    endtask

    // One idle cycle with junk on the data lines.
    task automatic send_idle();
        @(posedge clk);
        #1;
        in_valid        = 1'b0;
        req.dividend    = $urandom();
        req.divisor     = $urandom();
        req.is_unsigned = 1'($urandom_range(0, 1));
    endtask

    // Watchdog.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, not all divider results arrived within the cycle budget.");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    // Main stimulus.
    initial begin
        div_req_t r;
        int       seed_dummy;
        seed_dummy = $urandom(SEED);
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        req        = '0;
        cycle      = '0;
        exp_valid  = 1'b0;
        exp_cur    = '0;
        sent       = 0;

        // Reset for 8 cycles.
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Quiet stretch, output must stay low.
        repeat (6) begin
            send_idle();
        end

        // All corner pairs in both modes, one long burst.
        for (int i = 0; i < NUM_CORNERS; i++) begin
            for (int j = 0; j < NUM_CORNERS; j++) begin
                for (int m = 0; m < 2; m++) begin
                    r.dividend    = CORNERS[i];
                    r.divisor     = CORNERS[j];
                    r.is_unsigned = 1'(m);
                    send_request(r);
                end
            end
        end

        // Random requests, short gaps now and then.
        for (int k = 0; k < NUM_RANDOM; k++) begin
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 4)) begin
                    send_idle();
                end
            end
            r.dividend    = pick_operand();
            r.divisor     = pick_operand();
            r.is_unsigned = 1'($urandom_range(0, 1));
            send_request(r);
        end
        send_idle();

        // Drain, then a few cycles to catch stray strobes.
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule
